// ==== logic/display_pkg.sv ====
/*
 * Shared geometry, pixel types and default colors for the palette display path.
 * Imported by every block that handles coordinates, indices or YUV values.
 */

`default_nettype none

package display_pkg;

    localparam int frame_width  = 16;
    localparam int frame_height = 8;

    typedef logic [3:0] x_t;
    typedef logic [2:0] y_t;
    typedef logic [3:0] color_index_t;

    // packed as {y[3:0], u[2:0], v[2:0]}
    typedef logic [9:0] yuv_t;

    // row in the upper bits and column in the lower bits, so raster order is linear
    typedef logic [6:0] fb_addr_t;

    // entry 0 of the 16-color palette is the void color shown while the table is written
    localparam yuv_t default_palette [16] = '{
        10'b0000_011_011,  // void
        10'b1001_100_100,  // grey
        10'b1111_011_011,  // white
        10'b0101_011_110,  // red
        10'b1001_011_101,  // pink
        10'b0011_011_100,  // dark brown
        10'b0110_010_101,  // brown
        10'b1001_010_101,  // orange
        10'b1101_010_100,  // yellow
        10'b0100_100_011,  // dark green
        10'b0110_010_011,  // green
        10'b1010_001_011,  // light green
        10'b0010_100_011,  // night blue
        10'b0100_101_010,  // sea blue
        10'b1000_101_010,  // sky blue
        10'b1101_100_011   // cloud blue
    };

    localparam yuv_t void_color = default_palette[0];

endpackage

`default_nettype wire

// ==== logic/fb_write_if.sv ====
/*
 * Frame buffer write port, one pixel per cycle while enable is high.
 * The span drawer drives the source side and the frame buffer takes the sink side.
 */

`timescale 1ns/1ps
`default_nettype none

interface fb_write_if;
    import display_pkg::*;

    logic         enable;
    x_t           x;
    y_t           y;
    color_index_t index;

    modport source (output enable, x, y, index);
    modport sink   (input enable, x, y, index);

endinterface

`default_nettype wire

// ==== logic/span_drawer.sv ====
/*
 * Turns one horizontal span command into a run of frame buffer writes.
 * A strobe while idle starts the span, busy stays high for the clipped width.
 */

`timescale 1ns/1ps
`default_nettype none

module span_drawer (
    input  logic                      clock_in,
    input  logic                      reset_n_in,
    input  logic                      draw_strobe,
    input  display_pkg::x_t           draw_x,
    input  display_pkg::y_t           draw_y,
    input  logic [4:0]                draw_width,
    input  display_pkg::color_index_t draw_index,
    output logic                      draw_busy,
    fb_write_if.source                fb_write
);
    import display_pkg::*;

    logic         busy;
    logic         start;
    logic [4:0]   span_room;
    logic [4:0]   clipped_width;
    logic [4:0]   remaining;
    x_t           column;
    y_t           row;
    color_index_t index;

    // columns left between the start column and the right edge of the frame
    assign span_room     = 5'(frame_width) - 5'(draw_x);
    assign clipped_width = (draw_width > span_room) ? span_room : draw_width;

    // a zero width command would leave nothing to write, so it is not taken
    assign start = draw_strobe && !busy && (draw_width != 5'd0);

    always_ff @(posedge clock_in) begin
        if (!reset_n_in) begin
            busy <= 1'b0;
        end else if (start) begin
            busy <= 1'b1;
        end else if (busy && (remaining == 5'd1)) begin
            busy <= 1'b0;
        end
    end

    always_ff @(posedge clock_in) begin
        if (start) begin
            column    <= draw_x;
            row       <= draw_y;
            index     <= draw_index;
            remaining <= clipped_width;
        end else if (busy) begin
            column    <= column + x_t'(1);
            remaining <= remaining - 5'd1;
        end
    end

    // each busy cycle writes the pixel at the current column
    assign fb_write.enable = busy;
    assign fb_write.x      = column;
    assign fb_write.y      = row;
    assign fb_write.index  = index;

    assign draw_busy = busy;

endmodule

`default_nettype wire

// ==== logic/frame_buffer.sv ====
/*
 * Dual-port memory of color indices for the whole frame.
 * Written pixel by pixel by the span drawer, read in raster order by the scanout.
 */

`timescale 1ns/1ps
`default_nettype none

module frame_buffer (
    input  logic                      clock_in,
    fb_write_if.sink                  fb_write,
    input  display_pkg::fb_addr_t     read_addr,
    output display_pkg::color_index_t read_index
);
    import display_pkg::*;

    color_index_t memory [frame_width * frame_height];
    fb_addr_t     write_addr;

    // the row sits above the column bits, which gives the raster address directly
    assign write_addr = {fb_write.y, fb_write.x};

    always_ff @(posedge clock_in) begin
        if (fb_write.enable) begin
            memory[write_addr] <= fb_write.index;
        end
    end

    // the read is registered, so the index appears one cycle after its address
    always_ff @(posedge clock_in) begin
        read_index <= memory[read_addr];
    end

endmodule

`default_nettype wire

// ==== logic/color_palette.sv ====
/*
 * Reloadable 16-entry table that maps a color index to a YUV value.
 * Lookup has one cycle of latency and reset restores the default colors.
 */

`timescale 1ns/1ps
`default_nettype none

module color_palette (
    input  logic                      clock_in,
    input  logic                      reset_n_in,
    input  display_pkg::color_index_t pixel_index,
    output display_pkg::yuv_t         yuv_color,
    input  logic                      assign_enable,
    input  display_pkg::color_index_t assign_index,
    input  display_pkg::yuv_t         assign_value
);
    import display_pkg::*;

    yuv_t color_table [16];

    always_ff @(posedge clock_in) begin
        if (!reset_n_in) begin
            for (int i = 0; i < 16; i++) begin
                color_table[i] <= default_palette[i];
            end
        end else if (assign_enable) begin
            color_table[assign_index] <= assign_value;
        end
    end

    // while an entry is being replaced the lookup is skipped and void is shown
    always_ff @(posedge clock_in) begin
        if (!reset_n_in) begin
            yuv_color <= void_color;
        end else if (assign_enable) begin
            yuv_color <= void_color;
        end else begin
            yuv_color <= color_table[pixel_index];
        end
    end

endmodule

`default_nettype wire

// ==== logic/display_scanout.sv ====
/*
 * Raster counter that reads the frame buffer in order while enabled.
 * A two-stage delay line lines up pixel_valid and frame_start with the palette output.
 */

`timescale 1ns/1ps
`default_nettype none

module display_scanout (
    input  logic                  clock_in,
    input  logic                  reset_n_in,
    input  logic                  scan_enable,
    output display_pkg::fb_addr_t read_addr,
    output logic                  pixel_valid,
    output logic                  frame_start
);
    import display_pkg::*;

    fb_addr_t   raster_addr;
    logic [1:0] valid_pipe;
    logic [1:0] start_pipe;

    // the position only moves while scanning, so a pause resumes where it left off
    always_ff @(posedge clock_in) begin
        if (!reset_n_in) begin
            raster_addr <= '0;
        end else if (scan_enable) begin
            if (raster_addr == fb_addr_t'(frame_width * frame_height - 1)) begin
                raster_addr <= '0;
            end else begin
                raster_addr <= raster_addr + fb_addr_t'(1);
            end
        end
    end

    assign read_addr = raster_addr;

    // stage 0 covers the frame buffer read and stage 1 the palette lookup
    always_ff @(posedge clock_in) begin
        if (!reset_n_in) begin
            valid_pipe <= 2'b00;
            start_pipe <= 2'b00;
        end else begin
            valid_pipe[0] <= scan_enable;
            start_pipe[0] <= scan_enable && (raster_addr == '0);
            valid_pipe[1] <= valid_pipe[0];
            start_pipe[1] <= start_pipe[0];
        end
    end

    // pixels already issued still drain out after scan_enable drops
    assign pixel_valid = valid_pipe[1];
    assign frame_start = start_pipe[1];

endmodule

`default_nettype wire

// ==== logic/display_subsystem.sv ====
/*
 * Top level of the palette display path.
 * Span drawer fills the frame buffer, scanout reads it through the color palette.
 */

`timescale 1ns/1ps
`default_nettype none

module display_subsystem (
    input  logic                      clock_in,
    input  logic                      reset_n_in,
    input  logic                      draw_strobe,
    input  display_pkg::x_t           draw_x,
    input  display_pkg::y_t           draw_y,
    input  logic [4:0]                draw_width,
    input  display_pkg::color_index_t draw_index,
    output logic                      draw_busy,
    input  logic                      palette_write,
    input  display_pkg::color_index_t palette_index,
    input  display_pkg::yuv_t         palette_value,
    input  logic                      scan_enable,
    output logic                      pixel_valid,
    output logic                      frame_start,
    output display_pkg::yuv_t         pixel_yuv
);
    import display_pkg::*;

    fb_addr_t     read_addr;
    color_index_t read_index;

    fb_write_if fb_write ();

    span_drawer span_drawer_inst (
        .clock_in   (clock_in),
        .reset_n_in (reset_n_in),
        .draw_strobe(draw_strobe),
        .draw_x     (draw_x),
        .draw_y     (draw_y),
        .draw_width (draw_width),
        .draw_index (draw_index),
        .draw_busy  (draw_busy),
        .fb_write   (fb_write.source)
    );

    frame_buffer frame_buffer_inst (
        .clock_in  (clock_in),
        .fb_write  (fb_write.sink),
        .read_addr (read_addr),
        .read_index(read_index)
    );

    color_palette color_palette_inst (
        .clock_in     (clock_in),
        .reset_n_in   (reset_n_in),
        .pixel_index  (read_index),
        .yuv_color    (pixel_yuv),
        .assign_enable(palette_write),
        .assign_index (palette_index),
        .assign_value (palette_value)
    );

    display_scanout display_scanout_inst (
        .clock_in   (clock_in),
        .reset_n_in (reset_n_in),
        .scan_enable(scan_enable),
        .read_addr  (read_addr),
        .pixel_valid(pixel_valid),
        .frame_start(frame_start)
    );

endmodule

`default_nettype wire

// ==== sim/display_subsystem_tb.sv ====
/*
 * Self-checking testbench for the palette display path.
 * Draws, palette loads and pixel checks come from sim/display_testdata.txt,
 * followed by directed palette write, scan pause and reset sequences.
 */

`timescale 1ns/1ps
`default_nettype none

module display_subsystem_tb;
    import display_pkg::*;

    localparam int pixel_count = frame_width * frame_height;

    logic clock_in, reset_n_in, draw_strobe, draw_busy, palette_write;
    logic scan_enable, pixel_valid, frame_start;
    x_t           draw_x;
    y_t           draw_y;
    logic [4:0]   draw_width;
    color_index_t draw_index, palette_index;
    yuv_t         palette_value, pixel_yuv;

    // reference frame and palette that follow each command as it is applied
    color_index_t frame_model [pixel_count];
    logic         drawn [pixel_count];
    yuv_t         palette_model [16];

    display_subsystem display_subsystem_inst (.*);

    initial begin
        clock_in = 1'b0;
        forever begin
            #4 clock_in = ~clock_in;
        end
    end

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("TB FAILED");
        $fatal(1, "run aborted");
    endtask

    task automatic check_yuv(input string name, input yuv_t expected, input yuv_t actual);
        if (actual !== expected) begin
            $display("** Error: %s expected %h actual %h", name, expected, actual);
            $display("TB FAILED");
            $fatal(1, "yuv mismatch");
        end
    endtask

    task automatic check_status(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("** Error: %s expected %h actual %h", name, expected, actual);
            $display("TB FAILED");
            $fatal(1, "status mismatch");
        end
    endtask

    task automatic draw_span(input int x, input int y, input int width, input color_index_t index);
        int   clipped;
        int   count;
        logic done;
        clipped = (x + width > frame_width) ? frame_width - x : width;
        @(posedge clock_in);
        draw_strobe <= 1'b1;
        draw_x      <= x_t'(x);
        draw_y      <= y_t'(y);
        draw_width  <= 5'(width);
        draw_index  <= index;
        // a second command lands while busy and must not change the frame
        @(posedge clock_in);
        draw_x      <= '0;
        draw_y      <= y_t'(y + 1);
        draw_width  <= 5'd16;
        draw_index  <= ~index;
        @(posedge clock_in);
        draw_strobe <= 1'b0;
        count = 1;
        done  = 1'b0;
        while (!done) begin
            @(negedge clock_in);
            check_status("draw_busy", logic'(count < clipped), draw_busy);
            done = !draw_busy;
            count++;
            if (!done && count > 40) abort_run("timeout: draw_busy never fell");
        end
        for (int col = x; col < x + clipped; col++) begin
            frame_model[y * frame_width + col] = index;
            drawn[y * frame_width + col] = 1'b1;
        end
    endtask

    task automatic load_palette(input color_index_t index, input yuv_t value);
        @(posedge clock_in);
        palette_write <= 1'b1;
        palette_index <= index;
        palette_value <= value;
        @(posedge clock_in);
        palette_write <= 1'b0;
        palette_model[index] = value;
    endtask

    task automatic start_scan();
        @(posedge clock_in);
        scan_enable <= 1'b1;
    endtask

    task automatic stop_scan();
        int waited;
        @(posedge clock_in);
        scan_enable <= 1'b0;
        waited = 0;
        do begin
            @(negedge clock_in);
            waited++;
            if (pixel_valid && waited > 4) abort_run("timeout: pixel_valid never fell");
        end while (pixel_valid);
    endtask

    // waits for the first pixel, then checks count pixels in raster order from first
    task automatic check_pixels(input int first, input int count, input logic wait_start,
                                input int probe_addr, input yuv_t probe_yuv);
        int   addr;
        int   waited;
        logic found;
        waited = 0;
        found  = 1'b0;
        while (!found) begin
            @(negedge clock_in);
            found = wait_start ? frame_start : pixel_valid;
            waited++;
            if (!found && waited > 300) abort_run("timeout: no pixel came out of the scanout");
        end
        for (int k = 0; k < count; k++) begin
            if (k > 0) @(negedge clock_in);
            addr = (first + k) % pixel_count;
            check_status("pixel_valid", 1'b1, pixel_valid);
            check_status("frame_start", logic'(addr == 0), frame_start);
            if (drawn[addr]) check_yuv("pixel_yuv", palette_model[frame_model[addr]], pixel_yuv);
            if (addr == probe_addr) check_yuv("pixel_yuv", probe_yuv, pixel_yuv);
        end
    endtask

    task automatic run_testdata();
        int               fd;
        int               fields;
        int               arg0, arg1, arg2, arg3;
        logic [7:0]       kind;
        logic [8*128-1:0] rest;
        fd = $fopen("sim/display_testdata.txt", "r");
        if (fd == 0) abort_run("could not open sim/display_testdata.txt");
        while ($fscanf(fd, "%s", kind) == 1) begin
            case (kind)
                "#": fields = $fgets(rest, fd);
                "D": begin
                    fields = $fscanf(fd, "%d %d %d %h", arg0, arg1, arg2, arg3);
                    if (fields != 4) abort_run("draw line in test data is incomplete");
                    draw_span(arg0, arg1, arg2, color_index_t'(arg3));
                end
                "P": begin
                    fields = $fscanf(fd, "%h %h", arg0, arg1);
                    if (fields != 2) abort_run("palette line in test data is incomplete");
                    load_palette(color_index_t'(arg0), yuv_t'(arg1));
                end
                "C": begin
                    fields = $fscanf(fd, "%d %d %h", arg0, arg1, arg2);
                    if (fields != 3) abort_run("check line in test data is incomplete");
                    start_scan();
                    check_pixels(0, pixel_count + 1, 1'b1, arg1 * frame_width + arg0, yuv_t'(arg2));
                    stop_scan();
                end
                default: abort_run("unknown line kind in test data");
            endcase
        end
        $fclose(fd);
    endtask

    initial begin
        reset_n_in    = 1'b0;
        draw_strobe   = 1'b0;
        draw_x        = '0;
        draw_y        = '0;
        draw_width    = '0;
        draw_index    = '0;
        palette_write = 1'b0;
        palette_index = '0;
        palette_value = '0;
        scan_enable   = 1'b0;
        for (int i = 0; i < pixel_count; i++) drawn[i] = 1'b0;
        for (int i = 0; i < 16; i++) palette_model[i] = default_palette[i];
        repeat (4) @(posedge clock_in);
        reset_n_in <= 1'b1;

        run_testdata();

        // palette write in the middle of a scan shows void on exactly one pixel
        start_scan();
        check_pixels(0, 40, 1'b1, -1, '0);
        @(posedge clock_in);
        palette_write <= 1'b1;
        palette_index <= 4'h2;
        palette_value <= 10'h2aa;
        check_pixels(40, 1, 1'b0, -1, '0);
        @(posedge clock_in);
        palette_write <= 1'b0;
        @(negedge clock_in);
        check_status("pixel_valid", 1'b1, pixel_valid);
        check_yuv("pixel_yuv", void_color, pixel_yuv);
        palette_model[2] = 10'h2aa;
        check_pixels(42, pixel_count - 41, 1'b0, -1, '0);
        stop_scan();

        // pause after pixel 19, two pixels drain, then resume at pixel 22
        start_scan();
        check_pixels(0, 20, 1'b1, -1, '0);
        @(posedge clock_in);
        scan_enable <= 1'b0;
        check_pixels(20, 2, 1'b0, -1, '0);
        repeat (5) begin
            @(negedge clock_in);
            check_status("pixel_valid", 1'b0, pixel_valid);
        end
        @(posedge clock_in);
        scan_enable <= 1'b1;
        check_pixels(22, pixel_count - 21, 1'b0, -1, '0);
        stop_scan();

        // reset in the middle of a span while scanning
        @(posedge clock_in);
        draw_strobe <= 1'b1;
        draw_x      <= '0;
        draw_y      <= '0;
        draw_width  <= 5'd16;
        draw_index  <= 4'h3;
        scan_enable <= 1'b1;
        @(posedge clock_in);
        draw_strobe <= 1'b0;
        @(negedge clock_in);
        check_status("draw_busy", 1'b1, draw_busy);
        @(posedge clock_in);
        reset_n_in <= 1'b0;
        for (int i = 0; i < frame_width; i++) drawn[i] = 1'b0;
        repeat (4) begin
            @(posedge clock_in);
            @(negedge clock_in);
            check_status("draw_busy", 1'b0, draw_busy);
            check_status("pixel_valid", 1'b0, pixel_valid);
            check_status("frame_start", 1'b0, frame_start);
        end
        @(posedge clock_in);
        reset_n_in  <= 1'b1;
        scan_enable <= 1'b0;
        for (int i = 0; i < 16; i++) palette_model[i] = default_palette[i];
        draw_span(0, 0, 16, 4'h1);
        start_scan();
        check_pixels(0, pixel_count + 1, 1'b1, -1, '0);
        stop_scan();

        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/display_testdata.txt ====
# D x y width index : draw a span, x y width in decimal, index in hex
# P index value : load a palette entry, C x y yuv : scan a frame and check pixel x y
D 0 0 16 1
D 0 1 16 2
D 0 2 16 3
D 0 3 16 4
D 0 4 16 5
D 0 5 16 6
D 0 6 16 7
D 0 7 16 8
C 0 0 264
C 15 7 354
# clipped spans and short spans over the full frame
D 12 3 8 9
D 5 6 3 f
D 15 2 1 c
C 13 3 123
C 0 3 25d
C 6 6 363
C 8 6 255
C 15 2 0a3
# palette reload of two entries in use
P 4 3ff
P 9 001
C 3 3 3ff
C 14 3 001
C 0 0 264
C 4 6 255
C 9 5 195
C 7 4 0dc

// ==== tb.f ====
logic/display_pkg.sv
logic/fb_write_if.sv
logic/span_drawer.sv
logic/frame_buffer.sv
logic/color_palette.sv
logic/display_scanout.sv
logic/display_subsystem.sv
sim/display_subsystem_tb.sv

// ==== Bender.yml ====
package:
  name: display_subsystem

sources:
  - files:
      - logic/display_pkg.sv
      - logic/fb_write_if.sv
      - logic/span_drawer.sv
      - logic/frame_buffer.sv
      - logic/color_palette.sv
      - logic/display_scanout.sv
      - logic/display_subsystem.sv
  - target: simulation
    files:
      - sim/display_subsystem_tb.sv
